/* cache_pkg.sv */
package cache_pkg;

  // ----------------------------------------------------------
  // Bus and address geometry
  // ----------------------------------------------------------
  localparam int ADDR_WIDTH   = 32;
  localparam int DATA_WIDTH   = 32;
  // One 32-bit word per line
  localparam int OFFSET_WIDTH = 2;
  localparam int INDEX_WIDTH  = 3;
  localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int NUM_LINES    = 2 ** INDEX_WIDTH;

  // Two fetch ports, one id bit names the cache
  localparam int NUM_PORTS = 2;
  localparam int ID_WIDTH  = 1;

  // ----------------------------------------------------------
  // Backing memory
  // ----------------------------------------------------------
  // 64 words, decoded from address bits 7 to 2
  localparam int    MEM_WORDS_LOG2 = 6;
  localparam int    MEM_WORDS      = 2 ** MEM_WORDS_LOG2;
  localparam int    MEM_LATENCY    = 3;
  localparam int    LAT_WIDTH      = $clog2(MEM_LATENCY + 1);
  localparam string MEM_INIT_FILE  = "mem_init.hex";

  // Cache miss FSM encodings
  localparam int               STATE_WIDTH = 2;
  localparam [STATE_WIDTH-1:0] ST_IDLE     = 2'd0;
  localparam [STATE_WIDTH-1:0] ST_REQUEST  = 2'd1;
  localparam [STATE_WIDTH-1:0] ST_FILL     = 2'd2;

  // Fetch address, flat or split into cache fields
  typedef union packed {
    logic [ADDR_WIDTH-1:0] word;
    struct packed {
      logic [TAG_WIDTH-1:0]    tag;
      logic [INDEX_WIDTH-1:0]  index;
      logic [OFFSET_WIDTH-1:0] offset;
    } fields;
  } fetch_addr_t;

endpackage

/* fetch_cache.sv */
`timescale 1ns/100ps

module fetch_cache (
  input  logic                            clock,
  input  logic                            reset,
  // Fetch port
  input  logic                            fetch_valid,
  input  logic [cache_pkg::ADDR_WIDTH-1:0] fetch_addr,
  output logic                            fetch_ready,
  output logic [cache_pkg::DATA_WIDTH-1:0] fetch_data,
  // Read address channel
  output logic                            ar_valid,
  output logic [cache_pkg::ADDR_WIDTH-1:0] ar_addr,
  input  logic                            ar_ready,
  // Read data channel
  input  logic                            r_valid,
  input  logic [cache_pkg::DATA_WIDTH-1:0] r_data,
  output logic                            r_ready
);

  import cache_pkg::*;

  // Line storage
  logic [DATA_WIDTH-1:0] data_array [NUM_LINES];
  logic [TAG_WIDTH-1:0]  tag_array  [NUM_LINES];
  // Valid bit per tag, cleared by reset
  logic [NUM_LINES-1:0]  line_valid;

  // Split view of the fetch address
  fetch_addr_t            addr_view;
  logic [INDEX_WIDTH-1:0] line_index;
  logic [TAG_WIDTH-1:0]   line_tag;

  logic                   hit;
  logic                   miss;
  logic                   ar_handshake;
  logic                   r_handshake;

  logic [STATE_WIDTH-1:0] state;
  logic [STATE_WIDTH-1:0] state_next;

  // ----------------------------------------------------------
  // Lookup
  // ----------------------------------------------------------
  assign addr_view  = fetch_addr;
  assign line_index = addr_view.fields.index;
  assign line_tag   = addr_view.fields.tag;

  // Tag match on a valid line
  assign hit = fetch_valid && line_valid[line_index]
               && (tag_array[line_index] == line_tag);
  // Only idle looks at new addresses
  assign miss = (state == ST_IDLE) && fetch_valid && !hit;

  // Hit answers in the same cycle
  // fill answers the cycle after the R transfer
  assign fetch_ready = ((state == ST_IDLE) && hit) || (state == ST_FILL);
  assign fetch_data  = data_array[line_index];

  // ----------------------------------------------------------
  // Miss FSM
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        // Go fetch the missing word
        if (miss) begin
          state_next = ST_REQUEST;
        end
      end
      ST_REQUEST: begin
        // Wait through arbitration and memory latency
        if (r_handshake) begin
          state_next = ST_FILL;
        end
      end
      ST_FILL: begin
        // Line written, answer the port once
        state_next = ST_IDLE;
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Read address channel
  // ----------------------------------------------------------
  assign ar_handshake = ar_valid && ar_ready;
  // Outside holds the address during the miss
  assign ar_addr      = addr_view.word;

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_valid <= 1'b0;
    end else if (ar_handshake) begin
      ar_valid <= 1'b0;
    end else if (miss) begin
      // Raised the cycle after the miss is seen
      ar_valid <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Read data channel
  // ----------------------------------------------------------
  assign r_handshake = r_valid && r_ready;

  // Open for data once the address is taken
  always_ff @(posedge clock) begin
    if (reset) begin
      r_ready <= 1'b0;
    end else if (r_handshake) begin
      r_ready <= 1'b0;
    end else if (ar_handshake) begin
      r_ready <= 1'b1;
    end
  end

  // Line fill in the cycle of the R transfer
  always_ff @(posedge clock) begin
    if (r_handshake) begin
      data_array[line_index] <= r_data;
      tag_array[line_index]  <= line_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else if (r_handshake) begin
      line_valid[line_index] <= 1'b1;
    end
  end

endmodule

/* read_arbiter.sv */
`timescale 1ns/100ps

module read_arbiter (
  input  logic                                                   clock,
  input  logic                                                   reset,
  // Cache side
  input  logic [cache_pkg::NUM_PORTS-1:0]                        req_ar_valid,
  input  logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::ADDR_WIDTH-1:0] req_ar_addr,
  output logic [cache_pkg::NUM_PORTS-1:0]                        req_ar_ready,
  output logic [cache_pkg::NUM_PORTS-1:0]                        req_r_valid,
  output logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::DATA_WIDTH-1:0] req_r_data,
  input  logic [cache_pkg::NUM_PORTS-1:0]                        req_r_ready,
  // Memory side
  output logic                                                   mem_ar_valid,
  output logic [cache_pkg::ADDR_WIDTH-1:0]                       mem_ar_addr,
  output logic [cache_pkg::ID_WIDTH-1:0]                         mem_ar_id,
  input  logic                                                   mem_ar_ready,
  input  logic                                                   mem_r_valid,
  input  logic [cache_pkg::DATA_WIDTH-1:0]                       mem_r_data,
  input  logic [cache_pkg::ID_WIDTH-1:0]                         mem_r_id,
  output logic                                                   mem_r_ready
);

  import cache_pkg::*;

  logic                grant_valid;
  logic [ID_WIDTH-1:0] grant_id;
  // Last winner, next search starts after it
  logic [ID_WIDTH-1:0] last_id;
  // One read in flight until its R transfer
  logic                busy;

  logic                pick_valid;
  logic [ID_WIDTH-1:0] pick_id;
  logic                mem_ar_handshake;
  logic                mem_r_handshake;

  // ----------------------------------------------------------
  // Round-robin pick
  // ----------------------------------------------------------
  always_comb begin
    logic [ID_WIDTH-1:0] cand;
    pick_valid = 1'b0;
    pick_id    = last_id;
    cand       = last_id;
    // Walk from the port after the last winner, wrap to it last
    for (int i = 1; i <= NUM_PORTS; i++) begin
      cand = last_id + ID_WIDTH'(i);
      if (!pick_valid && req_ar_valid[cand]) begin
        pick_valid = 1'b1;
        pick_id    = cand;
      end
    end
  end

  assign mem_ar_handshake = mem_ar_valid && mem_ar_ready;
  assign mem_r_handshake  = mem_r_valid && mem_r_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      grant_valid <= 1'b0;
      grant_id    <= '0;
      // Cache 0 goes first
      last_id     <= ID_WIDTH'(NUM_PORTS - 1);
      busy        <= 1'b0;
    end else begin
      if (mem_ar_handshake) begin
        grant_valid <= 1'b0;
        last_id     <= grant_id;
        busy        <= 1'b1;
      end else if (!grant_valid && !busy && pick_valid) begin
        // Held until the address is taken
        grant_valid <= 1'b1;
        grant_id    <= pick_id;
      end
      if (mem_r_handshake) begin
        busy <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // Address channel to memory
  // ----------------------------------------------------------
  assign mem_ar_valid = grant_valid && req_ar_valid[grant_id];
  assign mem_ar_addr  = req_ar_addr[grant_id];
  assign mem_ar_id    = grant_id;

  // ----------------------------------------------------------
  // Ready back, response routed by id
  // ----------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      req_ar_ready[i] = grant_valid && (grant_id == ID_WIDTH'(i)) && mem_ar_ready;
      req_r_valid[i]  = mem_r_valid && (mem_r_id == ID_WIDTH'(i));
      // Data goes everywhere, valid picks the owner
      req_r_data[i]   = mem_r_data;
    end
  end

  assign mem_r_ready = req_r_ready[mem_r_id];

endmodule

/* backing_memory.sv */
`timescale 1ns/100ps

module backing_memory (
  input  logic                            clock,
  input  logic                            reset,
  // Read address channel
  input  logic                            ar_valid,
  input  logic [cache_pkg::ADDR_WIDTH-1:0] ar_addr,
  input  logic [cache_pkg::ID_WIDTH-1:0]   ar_id,
  output logic                            ar_ready,
  // Read data channel
  output logic                            r_valid,
  output logic [cache_pkg::DATA_WIDTH-1:0] r_data,
  output logic [cache_pkg::ID_WIDTH-1:0]   r_id,
  input  logic                            r_ready
);

  import cache_pkg::*;

  // Word array, contents from the data file
  logic [DATA_WIDTH-1:0] mem_array [MEM_WORDS];

  fetch_addr_t               addr_view;
  logic [MEM_WORDS_LOG2-1:0] word_index;
  // Latched request
  logic [MEM_WORDS_LOG2-1:0] read_index;
  logic [ID_WIDTH-1:0]       read_id;

  logic                      busy;
  logic [LAT_WIDTH-1:0]      count;
  logic                      ar_handshake;
  logic                      r_handshake;

  initial begin
    $readmemh(MEM_INIT_FILE, mem_array);
  end

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  assign addr_view  = ar_addr;
  // Bits 7 to 2, upper bits wrap
  assign word_index = addr_view.word[MEM_WORDS_LOG2+OFFSET_WIDTH-1:OFFSET_WIDTH];

  // Takes a read only when idle
  assign ar_ready     = !busy;
  assign ar_handshake = ar_valid && ar_ready;
  assign r_handshake  = r_valid && r_ready;

  // ----------------------------------------------------------
  // Latency counter
  // ----------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      busy  <= 1'b0;
      count <= '0;
    end else if (ar_handshake) begin
      busy  <= 1'b1;
      // Reaches zero MEM_LATENCY cycles after acceptance
      count <= LAT_WIDTH'(MEM_LATENCY - 1);
    end else if (busy) begin
      if (count != '0) begin
        count <= count - 1'b1;
      end else if (r_handshake) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_handshake) begin
      read_index <= word_index;
      read_id    <= ar_id;
    end
  end

  // ----------------------------------------------------------
  // Response, held until r_ready
  // ----------------------------------------------------------
  assign r_valid = busy && (count == '0);
  assign r_data  = mem_array[read_index];
  assign r_id    = read_id;

endmodule

/* fetch_subsystem.sv */
`timescale 1ns/100ps

module fetch_subsystem (
  input  logic                                                   clock,
  input  logic                                                   reset,
  input  logic [cache_pkg::NUM_PORTS-1:0]                        fetch_valid,
  input  logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::ADDR_WIDTH-1:0] fetch_addr,
  output logic [cache_pkg::NUM_PORTS-1:0]                        fetch_ready,
  output logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::DATA_WIDTH-1:0] fetch_data
);

  import cache_pkg::*;

  // ----------------------------------------------------------
  // Cache to arbiter
  // ----------------------------------------------------------
  logic [NUM_PORTS-1:0]                 req_ar_valid;
  logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] req_ar_addr;
  logic [NUM_PORTS-1:0]                 req_ar_ready;
  logic [NUM_PORTS-1:0]                 req_r_valid;
  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] req_r_data;
  logic [NUM_PORTS-1:0]                 req_r_ready;

  // Arbiter to memory
  logic                  mem_ar_valid;
  logic [ADDR_WIDTH-1:0] mem_ar_addr;
  logic [ID_WIDTH-1:0]   mem_ar_id;
  logic                  mem_ar_ready;
  logic                  mem_r_valid;
  logic [DATA_WIDTH-1:0] mem_r_data;
  logic [ID_WIDTH-1:0]   mem_r_id;
  logic                  mem_r_ready;

  // One private cache per fetch port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_cache
    fetch_cache u_cache (
      .clock       (clock),
      .reset       (reset),
      .fetch_valid (fetch_valid[p]),
      .fetch_addr  (fetch_addr[p]),
      .fetch_ready (fetch_ready[p]),
      .fetch_data  (fetch_data[p]),
      .ar_valid    (req_ar_valid[p]),
      .ar_addr     (req_ar_addr[p]),
      .ar_ready    (req_ar_ready[p]),
      .r_valid     (req_r_valid[p]),
      .r_data      (req_r_data[p]),
      .r_ready     (req_r_ready[p])
    );
  end

  read_arbiter u_arbiter (
    .clock        (clock),
    .reset        (reset),
    .req_ar_valid (req_ar_valid),
    .req_ar_addr  (req_ar_addr),
    .req_ar_ready (req_ar_ready),
    .req_r_valid  (req_r_valid),
    .req_r_data   (req_r_data),
    .req_r_ready  (req_r_ready),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar_addr  (mem_ar_addr),
    .mem_ar_id    (mem_ar_id),
    .mem_ar_ready (mem_ar_ready),
    .mem_r_valid  (mem_r_valid),
    .mem_r_data   (mem_r_data),
    .mem_r_id     (mem_r_id),
    .mem_r_ready  (mem_r_ready)
  );

  // Shared refill source
  backing_memory u_memory (
    .clock    (clock),
    .reset    (reset),
    .ar_valid (mem_ar_valid),
    .ar_addr  (mem_ar_addr),
    .ar_id    (mem_ar_id),
    .ar_ready (mem_ar_ready),
    .r_valid  (mem_r_valid),
    .r_data   (mem_r_data),
    .r_id     (mem_r_id),
    .r_ready  (mem_r_ready)
  );

endmodule

/* tb_fetch_subsystem.sv */
`timescale 1ns/100ps

module tb_fetch_subsystem;

  import cache_pkg::*;

  localparam int RANDOM_ROWS    = 24;
  localparam int CYCLES_PER_ROW = 40;

  logic                                 clock;
  logic                                 reset;
  logic [NUM_PORTS-1:0]                 fetch_valid;
  logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] fetch_addr;
  logic [NUM_PORTS-1:0]                 fetch_ready;
  logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] fetch_data;

  // Stimulus table with one entry per row across the queues
  logic [NUM_PORTS-1:0]  row_mask  [$];
  logic [ADDR_WIDTH-1:0] row_addr0 [$];
  logic [ADDR_WIDTH-1:0] row_addr1 [$];
  logic [NUM_PORTS-1:0]  row_hit   [$];
  // Directed rows carry their own hit flags
  logic                  row_fixed [$];

  // Reference model state
  logic [DATA_WIDTH-1:0] model_mem   [MEM_WORDS];
  logic [TAG_WIDTH-1:0]  model_tag   [NUM_PORTS][NUM_LINES];
  logic                  model_valid [NUM_PORTS][NUM_LINES];

  logic [31:0] lfsr_state;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          pass_count;
  int          fail_count;
  int          error_count;

  fetch_subsystem DUT (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_addr  (fetch_addr),
    .fetch_ready (fetch_ready),
    .fetch_data  (fetch_data)
  );

  // ----------------------------------------------------------
  // Clock and watchdog
  // ----------------------------------------------------------
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("ERROR: run timed out after %0d cycles", cycle_count);
      $display("tests: %0d passed, %0d failed, %0d other errors",
               pass_count, fail_count, error_count);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------
  // Random source and reference model
  // ----------------------------------------------------------
  // Galois LFSR stepped once per bit
  function automatic logic take_random_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'hA300_0000;
    end
    return out;
  endfunction

  function automatic logic [31:0] take_random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[30:0], take_random_bit()};
    end
    return value;
  endfunction

  // Hit when the line last held this tag
  // Every access leaves its tag behind
  function automatic logic predict_hit(input int port, input logic [ADDR_WIDTH-1:0] addr);
    logic [INDEX_WIDTH-1:0] index;
    logic [TAG_WIDTH-1:0]   tag;
    logic                   hit;
    index = addr[OFFSET_WIDTH +: INDEX_WIDTH];
    tag   = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    hit   = model_valid[port][index] && (model_tag[port][index] == tag);
    model_valid[port][index] = 1'b1;
    model_tag[port][index]   = tag;
    return hit;
  endfunction

  // Memory word at address bits 7 to 2
  function automatic logic [DATA_WIDTH-1:0] expected_word(input logic [ADDR_WIDTH-1:0] addr);
    return model_mem[addr[OFFSET_WIDTH +: MEM_WORDS_LOG2]];
  endfunction

  // ----------------------------------------------------------
  // Table construction
  // ----------------------------------------------------------
  task automatic add_row(input logic [NUM_PORTS-1:0] mask, input logic [ADDR_WIDTH-1:0] a0,
                         input logic [ADDR_WIDTH-1:0] a1, input logic [NUM_PORTS-1:0] hit,
                         input logic fixed);
    row_mask.push_back(mask);
    row_addr0.push_back(a0);
    row_addr1.push_back(a1);
    row_hit.push_back(hit);
    row_fixed.push_back(fixed);
  endtask

  task automatic build_table();
    logic [NUM_PORTS-1:0]  mask;
    logic [ADDR_WIDTH-1:0] a0;
    logic [ADDR_WIDTH-1:0] a1;
    // Cold miss then hits on the same word
    add_row(2'b01, 32'h0000_0010, 32'h0, 2'b00, 1'b1);
    add_row(2'b01, 32'h0000_0010, 32'h0, 2'b01, 1'b1);
    add_row(2'b01, 32'h0000_0010, 32'h0, 2'b01, 1'b1);
    // Index 4 with alternating tags
    add_row(2'b01, 32'h0000_0030, 32'h0, 2'b00, 1'b1);
    add_row(2'b01, 32'h0000_0010, 32'h0, 2'b00, 1'b1);
    add_row(2'b01, 32'h0000_0030, 32'h0, 2'b00, 1'b1);
    // High tag wraps to memory word 4
    add_row(2'b01, 32'h1000_0010, 32'h0, 2'b00, 1'b1);
    // Line that cache 0 now holds is still cold in cache 1
    add_row(2'b10, 32'h0, 32'h1000_0010, 2'b00, 1'b1);
    add_row(2'b10, 32'h0, 32'h1000_0010, 2'b10, 1'b1);
    // Both ports miss together
    add_row(2'b11, 32'h0000_0044, 32'h0000_0088, 2'b00, 1'b1);
    add_row(2'b11, 32'h0000_0044, 32'h0000_0088, 2'b11, 1'b1);
    add_row(2'b11, 32'h0000_000C, 32'h0000_000C, 2'b00, 1'b1);
    // One hit beside one miss
    add_row(2'b11, 32'h0000_0044, 32'h0000_00FC, 2'b01, 1'b1);
    // Small address space so that hits recur
    for (int i = 0; i < RANDOM_ROWS; i++) begin
      mask = take_random_bits(2);
      if (mask == '0) begin
        mask = '1;
      end
      a0 = take_random_bits(5) << OFFSET_WIDTH;
      a1 = take_random_bits(5) << OFFSET_WIDTH;
      add_row(mask, a0, a1, 2'b00, 1'b0);
    end
  endtask

  // ----------------------------------------------------------
  // Row application and checks
  // ----------------------------------------------------------
  task automatic check_response(input int idx, input int port,
                                input logic [ADDR_WIDTH-1:0] addr, input logic exp_hit,
                                input logic got_hit, input logic [DATA_WIDTH-1:0] data);
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  ok;
    exp_data = expected_word(addr);
    ok       = 1'b1;
    if (got_hit != exp_hit) begin
      $display("mismatch at %0t: row %0d port %0d addr %h hit=%0d, expected hit=%0d",
               $time, idx, port, addr, got_hit, exp_hit);
      ok = 1'b0;
    end
    if (data !== exp_data) begin
      $display("mismatch at %0t: row %0d port %0d addr %h data %h, expected %h",
               $time, idx, port, addr, data, exp_data);
      ok = 1'b0;
    end
    if (ok) begin
      pass_count++;
      $display("row %0d port %0d addr %h %s data %h ok", idx, port, addr,
               exp_hit ? "hit " : "miss", data);
    end else begin
      fail_count++;
      $display("row %0d port %0d addr %h failed", idx, port, addr);
    end
  endtask

  task automatic apply_row(input int idx);
    logic [NUM_PORTS-1:0]  pending;
    logic [NUM_PORTS-1:0]  exp_hit;
    logic [ADDR_WIDTH-1:0] addr [NUM_PORTS];
    logic                  first;
    addr[0] = row_addr0[idx];
    addr[1] = row_addr1[idx];
    pending = row_mask[idx];
    exp_hit = '0;
    first   = 1'b1;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (pending[p]) begin
        exp_hit[p] = predict_hit(p, addr[p]);
        if (row_fixed[idx] && (exp_hit[p] != row_hit[idx][p])) begin
          $display("ERROR: row %0d port %0d lists hit=%0d but the model predicts hit=%0d",
                   idx, p, row_hit[idx][p], exp_hit[p]);
          error_count++;
        end
      end
    end
    @(posedge clock);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (pending[p]) begin
        fetch_valid[p] <= 1'b1;
        fetch_addr[p]  <= addr[p];
      end
    end
    // Sample mid-cycle and release each port after its transfer
    while (pending != '0) begin
      @(negedge clock);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (pending[p] && fetch_ready[p]) begin
          check_response(idx, p, addr[p], exp_hit[p], first, fetch_data[p]);
          pending[p] = 1'b0;
        end
      end
      first = 1'b0;
      @(posedge clock);
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (!pending[p]) begin
          fetch_valid[p] <= 1'b0;
        end
      end
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    reset       = 1'b1;
    fetch_valid = '0;
    fetch_addr  = '0;
    lfsr_state  = 32'hd265;
    pass_count  = 0;
    fail_count  = 0;
    error_count = 0;
    $readmemh("mem_init.hex", model_mem);
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int i = 0; i < NUM_LINES; i++) begin
        model_valid[p][i] = 1'b0;
        model_tag[p][i]   = '0;
      end
    end
    build_table();
    cycle_limit = row_mask.size() * CYCLES_PER_ROW;
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < row_mask.size(); i++) begin
      apply_row(i);
    end
    $display("tests: %0d passed, %0d failed, %0d other errors",
             pass_count, fail_count, error_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* mem_init.hex */
// One 32-bit word per line in hex, line n is word n
// Word n holds n, A5, FF minus n, and its byte address 4*n
00A5FF00
01A5FE04
02A5FD08
03A5FC0C
04A5FB10
05A5FA14
06A5F918
07A5F81C
08A5F720
09A5F624
0AA5F528
0BA5F42C
0CA5F330
0DA5F234
0EA5F138
0FA5F03C
10A5EF40
11A5EE44
12A5ED48
13A5EC4C
14A5EB50
15A5EA54
16A5E958
17A5E85C
18A5E760
19A5E664
1AA5E568
1BA5E46C
1CA5E370
1DA5E274
1EA5E178
1FA5E07C
20A5DF80
21A5DE84
22A5DD88
23A5DC8C
24A5DB90
25A5DA94
26A5D998
27A5D89C
28A5D7A0
29A5D6A4
2AA5D5A8
2BA5D4AC
2CA5D3B0
2DA5D2B4
2EA5D1B8
2FA5D0BC
30A5CFC0
31A5CEC4
32A5CDC8
33A5CCCC
34A5CBD0
35A5CAD4
36A5C9D8
37A5C8DC
38A5C7E0
39A5C6E4
3AA5C5E8
3BA5C4EC
3CA5C3F0
3DA5C2F4
3EA5C1F8
3FA5C0FC

/* compile.f */
cache_pkg.sv
fetch_cache.sv
read_arbiter.sv
backing_memory.sv
fetch_subsystem.sv
tb_fetch_subsystem.sv

/* Bender.yml */
package:
  name: fetch_subsystem

sources:
  - files:
      - cache_pkg.sv
      - fetch_cache.sv
      - read_arbiter.sv
      - backing_memory.sv
      - fetch_subsystem.sv
  - target: test
    files:
      - tb_fetch_subsystem.sv
